// File: Bender.yml
package:
  name: rack_emg

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mn_pool_pkg.sv
      - rtl/trigger_param_bank.sv
      - rtl/sim_tick_gen.sv
      - rtl/afferent_synapse.sv
      - rtl/motoneuron_pool.sv
      - rtl/rack_emg_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - tb/tb_rack_emg.sv

// File: project.f
+incdir+rtl
rtl/mn_pool_pkg.sv
rtl/trigger_param_bank.sv
rtl/sim_tick_gen.sv
rtl/afferent_synapse.sv
rtl/motoneuron_pool.sv
rtl/rack_emg_top.sv
tb/tb_rack_emg.sv

// File: rtl/afferent_synapse.sv
`timescale 1ns/1ps
`include "mn_pool_defs.svh"

module afferent_synapse
    import mn_pool_pkg::*;
(
    input  logic   ep50trig,
    input  logic   reset_global,
    input  logic   i_spike_in,      // afferent spike train, clock synchronous
    input  logic   i_sim_tick,      // window boundary
    input  word_t  i_syn_gain,
    input  word_t  i_syn_offset,
    output word_t  o_current,       // held for the whole next window
    output count_t o_input_count    // edges of the last closed window
);

    logic   spike_d;       // previous input sample
    logic   spike_edge;
    count_t edge_cnt;      // edges so far in this window
    count_t window_cnt;    // closing count incl. this cycle's edge
    word_t  above_offset;  // count minus offset, floored

    assign spike_edge = i_spike_in & ~spike_d;
    assign window_cnt = edge_cnt + count_t'(spike_edge);

    // no negative current, counts under the offset give zero
    assign above_offset = (word_t'(window_cnt) > i_syn_offset)
                        ? word_t'(window_cnt) - i_syn_offset
                        : '0;

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            spike_d       <= 1'b0;
            edge_cnt      <= '0;
            o_current     <= '0;
            o_input_count <= '0;
        end else begin
            spike_d <= i_spike_in;
            if (i_sim_tick) begin
                o_input_count <= window_cnt;
                o_current     <= above_offset * i_syn_gain;  // wraps at 32 bits
                edge_cnt      <= '0;                         // new window
            end else begin
                edge_cnt <= window_cnt;
            end
        end
    end

endmodule

// File: rtl/mn_pool_defs.svh
`ifndef MN_POOL_DEFS_SVH
`define MN_POOL_DEFS_SVH

// datapath widths
`define MN_WORD_W    32
`define MN_COUNT_W   16
`define MN_ADDR_W    2

// pool size and fixed scaling
`define MN_NUM_MN                7
`define MN_NEURON_TICKS_PER_SIM  128  // neuron ticks per 1 ms sim step
`define MN_TH_SHIFT              10   // threshold scaled by 1024
`define MN_SIZE_SHIFT            3    // size weights are in eighths

// register map, one word per register
`define MN_ADDR_THRESHOLD    2'd0
`define MN_ADDR_SYN_GAIN     2'd1
`define MN_ADDR_SYN_OFFSET   2'd2
`define MN_ADDR_TICK_PERIOD  2'd3

// reset defaults
`define MN_DEF_THRESHOLD     32'd30
`define MN_DEF_SYN_GAIN      32'd100
`define MN_DEF_SYN_OFFSET    32'd0
`define MN_DEF_TICK_PERIOD   32'd381  // close to real time with a ~48.8 MHz clock

`endif

// File: rtl/mn_pool_pkg.sv
`include "mn_pool_defs.svh"

package mn_pool_pkg;

    typedef logic [`MN_WORD_W-1:0]  word_t;        // parameter word, synaptic current
    typedef logic [`MN_COUNT_W-1:0] count_t;       // spikes per window
    typedef logic [`MN_WORD_W-1:0]  total_t;       // muap weighted pool total
    typedef logic [`MN_ADDR_W-1:0]  param_addr_t;  // register select

    // tick generator
    typedef enum logic {
        TICK_IDLE,  // single cycle after reset
        TICK_RUN    // period counter running
    } tick_state_e;

    // size principle input scaling, index 0 is the smallest unit
    // small units see the largest share of the current and recruit first
    localparam logic [7:0] size_weight_table [`MN_NUM_MN] = '{
        8'd75,
        8'd49,
        8'd30,
        8'd17,
        8'd13,
        8'd10,
        8'd8
    };

    // muap amplitude per unit, grows with unit size
    localparam logic [7:0] muap_weight_table [`MN_NUM_MN] = '{
        8'd1,
        8'd3,
        8'd6,
        8'd15,
        8'd22,
        8'd34,
        8'd49
    };

endpackage

// File: rtl/motoneuron_pool.sv
`timescale 1ns/1ps
`include "mn_pool_defs.svh"

module motoneuron_pool
    import mn_pool_pkg::*;
(
    input  logic                  ep50trig,
    input  logic                  reset_global,
    input  logic                  i_neuron_tick,   // integration step
    input  logic                  i_sim_tick,      // window boundary
    input  word_t                 i_current,       // shared synaptic current
    input  word_t                 i_threshold,     // unscaled, common to all units
    output logic [`MN_NUM_MN-1:0] o_mn_spikes,     // per unit spike pulse
    output total_t                o_total_spikes,  // muap weighted window total
    output logic                  o_window_valid   // one cycle per window
);

    // headroom for current*75 and threshold<<10
    localparam int ACC_W = 48;

    logic [ACC_W-1:0]      acc         [`MN_NUM_MN];  // membrane state
    logic [ACC_W-1:0]      acc_sum     [`MN_NUM_MN];  // state plus this step's input
    logic [ACC_W-1:0]      th_scaled;
    logic [`MN_NUM_MN-1:0] fire;
    count_t                spk_cnt     [`MN_NUM_MN];  // running, this window
    count_t                cnt_window  [`MN_NUM_MN];  // incl. spike on this tick
    count_t                cnt_latched [`MN_NUM_MN];  // last closed window
    logic                  sim_tick_d;                // counts latched last cycle
    total_t                weighted_sum;

    always_comb begin
        th_scaled    = ACC_W'(i_threshold) << `MN_TH_SHIFT;
        weighted_sum = '0;
        for (int i = 0; i < `MN_NUM_MN; i++) begin
            // size principle, current * weight / 8
            acc_sum[i] = acc[i]
                       + ((ACC_W'(i_current) * ACC_W'(size_weight_table[i])) >> `MN_SIZE_SHIFT);
            fire[i]       = i_neuron_tick && (acc_sum[i] >= th_scaled);
            cnt_window[i] = spk_cnt[i] + count_t'(fire[i]);
            weighted_sum  = weighted_sum
                          + total_t'(cnt_latched[i]) * total_t'(muap_weight_table[i]);
        end
    end

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            for (int i = 0; i < `MN_NUM_MN; i++) begin
                acc[i]         <= '0;
                spk_cnt[i]     <= '0;
                cnt_latched[i] <= '0;
            end
            o_mn_spikes    <= '0;
            sim_tick_d     <= 1'b0;
            o_total_spikes <= '0;
            o_window_valid <= 1'b0;
        end else begin
            o_mn_spikes    <= fire;
            sim_tick_d     <= i_sim_tick;
            o_window_valid <= sim_tick_d;   // total lands with the pulse
            if (sim_tick_d) begin
                o_total_spikes <= weighted_sum;
            end
            for (int i = 0; i < `MN_NUM_MN; i++) begin
                if (i_neuron_tick) begin
                    // at most one spike per step, excess carries over
                    acc[i] <= fire[i] ? acc_sum[i] - th_scaled : acc_sum[i];
                end
                if (i_sim_tick) begin
                    cnt_latched[i] <= cnt_window[i];
                    spk_cnt[i]     <= '0;
                end else begin
                    spk_cnt[i] <= cnt_window[i];
                end
            end
        end
    end

    // windows are >=128 cycles apart, a longer pulse means a tick glitch upstream
    a_valid_single: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        o_window_valid |=> !o_window_valid
    ) else $error("window valid held longer than one cycle");

endmodule

// File: rtl/rack_emg_top.sv
`timescale 1ns/1ps
`include "mn_pool_defs.svh"

module rack_emg_top
    import mn_pool_pkg::*;
(
    input  logic                  ep50trig,
    input  logic                  reset_global,
    input  logic                  i_spike_in,      // afferent input
    input  logic                  i_load,          // parameter load strobe
    input  param_addr_t           i_load_addr,
    input  word_t                 i_load_data,
    output logic [`MN_NUM_MN-1:0] o_mn_spikes,
    output total_t                o_total_spikes,
    output count_t                o_input_count,   // same window as the total
    output logic                  o_window_valid
);

    word_t threshold;
    word_t syn_gain;
    word_t syn_offset;
    word_t tick_period;
    logic  neuron_tick;
    logic  sim_tick;
    word_t current;     // synapse to pool

    trigger_param_bank u_param_bank (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_load        (i_load),
        .i_load_addr   (i_load_addr),
        .i_load_data   (i_load_data),
        .o_threshold   (threshold),
        .o_syn_gain    (syn_gain),
        .o_syn_offset  (syn_offset),
        .o_tick_period (tick_period)
    );

    sim_tick_gen u_tick_gen (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_tick_period (tick_period),
        .o_neuron_tick (neuron_tick),
        .o_sim_tick    (sim_tick)
    );

    afferent_synapse u_synapse (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_spike_in    (i_spike_in),
        .i_sim_tick    (sim_tick),
        .i_syn_gain    (syn_gain),
        .i_syn_offset  (syn_offset),
        .o_current     (current),
        .o_input_count (o_input_count)
    );

    motoneuron_pool u_pool (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .i_neuron_tick  (neuron_tick),
        .i_sim_tick     (sim_tick),
        .i_current      (current),
        .i_threshold    (threshold),
        .o_mn_spikes    (o_mn_spikes),
        .o_total_spikes (o_total_spikes),
        .o_window_valid (o_window_valid)
    );

endmodule

// File: rtl/sim_tick_gen.sv
`timescale 1ns/1ps
`include "mn_pool_defs.svh"

module sim_tick_gen
    import mn_pool_pkg::*;
(
    input  logic  ep50trig,
    input  logic  reset_global,
    input  word_t i_tick_period,   // clocks per neuron tick
    output logic  o_neuron_tick,   // one cycle pulse
    output logic  o_sim_tick       // every 128th neuron tick, same cycle
);

    tick_state_e state;
    word_t       period_cnt;      // clocks since last neuron tick
    logic [6:0]  ntick_cnt;       // neuron ticks in current window
    word_t       period_eff;
    logic        tick_due;

    assign period_eff = (i_tick_period == '0) ? word_t'(1) : i_tick_period; // 0 acts as 1
    // >= so a shorter period loaded mid count fires right away
    assign tick_due   = (state == TICK_RUN) && (period_cnt >= period_eff - word_t'(1));

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            state         <= TICK_IDLE;
            period_cnt    <= '0;
            ntick_cnt     <= '0;
            o_neuron_tick <= 1'b0;
            o_sim_tick    <= 1'b0;
        end else begin
            o_neuron_tick <= tick_due;
            o_sim_tick    <= tick_due && (ntick_cnt == 7'(`MN_NEURON_TICKS_PER_SIM - 1));
            case (state)
                TICK_IDLE: state <= TICK_RUN;   // one dead cycle after reset
                TICK_RUN: begin
                    if (tick_due) begin
                        period_cnt <= '0;
                        ntick_cnt  <= ntick_cnt + 7'd1;  // wraps after 128
                    end else begin
                        period_cnt <= period_cnt + word_t'(1);
                    end
                end
            endcase
        end
    end

    // an unknown period would stall the compare and every tick after it
    a_period_known: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        !$isunknown(i_tick_period)
    ) else $error("tick period unknown");

endmodule

// File: rtl/trigger_param_bank.sv
`timescale 1ns/1ps
`include "mn_pool_defs.svh"

module trigger_param_bank
    import mn_pool_pkg::*;
(
    input  logic        ep50trig,       // system clock
    input  logic        reset_global,   // async, active high
    input  logic        i_load,         // load strobe, one register per edge
    input  param_addr_t i_load_addr,    // which register
    input  word_t       i_load_data,    // value to store
    output word_t       o_threshold,    // unscaled threshold
    output word_t       o_syn_gain,
    output word_t       o_syn_offset,
    output word_t       o_tick_period   // clocks per neuron tick
);

    // each register comes up at its own default
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_threshold   <= `MN_DEF_THRESHOLD;
            o_syn_gain    <= `MN_DEF_SYN_GAIN;
            o_syn_offset  <= `MN_DEF_SYN_OFFSET;
            o_tick_period <= `MN_DEF_TICK_PERIOD;
        end else if (i_load) begin
            case (i_load_addr)
                `MN_ADDR_THRESHOLD: begin
                    o_threshold <= i_load_data;   // pool applies the x1024
                end
                `MN_ADDR_SYN_GAIN: begin
                    o_syn_gain <= i_load_data;
                end
                `MN_ADDR_SYN_OFFSET: begin
                    o_syn_offset <= i_load_data;  // in input edges per window
                end
                `MN_ADDR_TICK_PERIOD: begin
                    o_tick_period <= i_load_data; // takes effect at next compare
                end
            endcase
        end
    end

    // a strobe with an X address would drop the load without a trace
    a_load_addr_known: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        i_load |-> !$isunknown(i_load_addr)
    ) else $error("param bank load with unknown address");

endmodule

// File: tb/tb_rack_emg.sv
`timescale 1ns/1ps
`include "mn_pool_defs.svh"

module tb_rack_emg
    import mn_pool_pkg::*;
();

    logic                  ep50trig;
    logic                  reset_global;
    logic                  i_spike_in;
    logic                  i_load;
    param_addr_t           i_load_addr;
    word_t                 i_load_data;
    logic [`MN_NUM_MN-1:0] o_mn_spikes;
    total_t                o_total_spikes;
    count_t                o_input_count;
    logic                  o_window_valid;

    // per unit weights, smallest unit first
    localparam int size_w [7] = '{75, 49, 30, 17, 13, 10, 8};
    localparam int muap_w [7] = '{1, 3, 6, 15, 22, 34, 49};

    word_t       par_threshold = `MN_DEF_THRESHOLD;  // what the bank should hold
    word_t       par_gain      = `MN_DEF_SYN_GAIN;
    word_t       par_offset    = `MN_DEF_SYN_OFFSET;
    word_t       par_period    = `MN_DEF_TICK_PERIOD;
    logic [63:0] ref_acc [7]   = '{default: '0};     // model membrane state
    int          ref_spikes [7];                      // model spikes, last window
    total_t      ref_total;                           // model total, last window
    word_t       ref_cur       = '0;                  // current for the running window
    int          mon_edges     = 0;                   // input edges since last result
    int          mon_spikes [7];                      // observed unit pulses this window
    logic        mon_prev      = 1'b0;
    logic [15:0] lfsr          = 16'd62;
    string       test_name     = "none";
    int          err_count     = 0;
    int          check_count   = 0;
    int          errs_at_start = 0;
    int          tests_run     = 0;
    int          tests_failed  = 0;
    int          cycles;

    rack_emg_top u_rack_emg_top (.*);

    always #50 ep50trig = ~ep50trig;  // 100 ns

    // x^16 + x^14 + x^13 + x^11 + 1, one new bit per call
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic word_t syn_current(input int edges, input word_t off, input word_t gain);
        if (word_t'(edges) > off) begin
            return (word_t'(edges) - off) * gain;  // 32 bit product
        end
        return '0;
    endfunction

    // one window of 128 neuron ticks at a constant current
    function automatic total_t ref_window_total(input word_t cur);
        logic [63:0] th;
        int unsigned per;
        total_t      sum;
        th  = 64'(par_threshold) << 10;
        per = (par_period == 0) ? 1 : par_period;  // zero period ticks every cycle
        sum = '0;
        for (int k = 0; k < 7; k++) ref_spikes[k] = 0;
        for (int unsigned cyc = 1; cyc <= 128 * per; cyc++) begin
            if (cyc % per == 0) begin             // neuron tick
                for (int k = 0; k < 7; k++) begin
                    ref_acc[k] = ref_acc[k] + ((64'(cur) * size_w[k]) >> 3);
                    if (ref_acc[k] >= th) begin
                        ref_acc[k] = ref_acc[k] - th;  // one spike per tick at most
                        ref_spikes[k]++;
                    end
                end
            end
        end
        for (int k = 0; k < 7; k++) sum = sum + total_t'(ref_spikes[k] * muap_w[k]);
        return sum;
    endfunction

    task automatic compare_total(input string name, input total_t exp, input total_t act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("Mismatch %s: total expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic compare_count(input string name, input count_t exp, input count_t act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("Mismatch %s: input count expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic compare_spikes(input string name, input int unit, input count_t exp,
                                  input count_t act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("Mismatch %s: unit %0d spikes expected %0d, actual %0d",
                     name, unit, exp, act);
        end
    endtask

    // result checker, edges counted from the driven input itself
    always @(posedge ep50trig) begin
        if (reset_global) begin
            mon_edges = 0;
            mon_prev  = 1'b0;
            for (int k = 0; k < 7; k++) begin
                mon_spikes[k] = 0;
            end
        end else begin
            if (i_spike_in && !mon_prev) mon_edges++;
            mon_prev = i_spike_in;
            if (o_window_valid) begin
                ref_total = ref_window_total(ref_cur);  // also fills ref_spikes
                compare_count(test_name, count_t'(mon_edges), o_input_count);
                compare_total(test_name, ref_total, o_total_spikes);
                for (int k = 0; k < 7; k++) begin
                    compare_spikes(test_name, k, count_t'(ref_spikes[k]),
                                   count_t'(mon_spikes[k]));
                    mon_spikes[k] = 0;
                end
                ref_cur   = syn_current(mon_edges, par_offset, par_gain);  // next window
                mon_edges = 0;
            end
            // pulses seen here come from ticks after the boundary
            for (int k = 0; k < 7; k++) begin
                if (o_mn_spikes[k]) mon_spikes[k]++;
            end
        end
    end

    task automatic wait_window(input int limit, output int n);
        n = 0;
        do begin
            @(posedge ep50trig);
            n++;
        end while (!o_window_valid && n < limit);
        if (!o_window_valid) begin
            $display("Timeout in %s: no window result within %0d cycles", test_name, limit);
            $display("Verification failed");
            $finish;
        end
    endtask

    task automatic load_param(input param_addr_t addr, input word_t data);
        i_load      <= 1'b1;
        i_load_addr <= addr;
        i_load_data <= data;
        @(posedge ep50trig);    // bank takes it here
        i_load      <= 1'b0;
        case (addr)
            `MN_ADDR_THRESHOLD:  par_threshold = data;
            `MN_ADDR_SYN_GAIN:   par_gain      = data;
            `MN_ADDR_SYN_OFFSET: par_offset    = data;
            default:             par_period    = data;
        endcase
    endtask

    task automatic pulse_window(input int n);
        for (int p = 0; p < n; p++) begin
            i_spike_in <= 1'b1;
            @(posedge ep50trig);
            i_spike_in <= 1'b0;
            @(posedge ep50trig);
        end
    endtask

    // random toggles, back low well before the window closes
    task automatic random_window();
        logic level;
        level = 1'b0;
        for (int c = 0; c < 200; c++) begin
            lfsr  = lfsr_step(lfsr);
            level = level ^ lfsr[0];
            i_spike_in <= level;
            @(posedge ep50trig);
        end
        i_spike_in <= 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        errs_at_start = err_count;
    endtask

    task automatic end_test();
        @(posedge ep50trig);  // checker has seen the last result
        tests_run++;
        if (err_count == errs_at_start) begin
            $display("test %-14s ok", test_name);
        end else begin
            tests_failed++;
            $display("test %-14s FAIL, %0d errors", test_name, err_count - errs_at_start);
        end
    endtask

    initial begin
        ep50trig     = 1'b0;
        reset_global = 1'b1;
        i_spike_in   = 1'b0;
        i_load       = 1'b0;
        i_load_addr  = '0;
        i_load_data  = '0;
        repeat (2) @(posedge ep50trig);
        reset_global <= 1'b0;

        begin_test("reset_window");
        wait_window(128 * 381 + 64, cycles);  // default period
        end_test();

        begin_test("param_load");
        load_param(`MN_ADDR_TICK_PERIOD, 32'd2);
        load_param(`MN_ADDR_SYN_GAIN, 32'd100);
        load_param(`MN_ADDR_THRESHOLD, 32'd30);
        wait_window(128 * 381 + 64, cycles);  // window spanning the change
        wait_window(300, cycles);
        check_count++;
        if (cycles != 256) begin
            err_count++;
            $display("Mismatch %s: window spacing expected 256, actual %0d", test_name, cycles);
        end
        end_test();

        begin_test("fixed_input");
        repeat (4) begin
            pulse_window(3);  // current 300 from the second window on
            wait_window(300, cycles);
        end
        end_test();

        begin_test("offset_cut");
        load_param(`MN_ADDR_SYN_OFFSET, 32'd50);
        repeat (3) begin
            pulse_window(3);
            wait_window(300, cycles);
        end
        compare_total(test_name, '0, o_total_spikes);
        end_test();

        begin_test("random_input");
        load_param(`MN_ADDR_SYN_OFFSET, 32'd0);
        repeat (6) begin
            random_window();
            wait_window(300, cycles);
        end
        end_test();

        $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, err_count);
        if (err_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
